// File: na_pkg.sv
/*
 * Network adapter package with widths, bus address map, NoC class codes and
 * the payload types shared by the message-passing path
 */
package na_pkg;

   // Data path widths
   localparam int FLIT_WIDTH = 32;
   localparam int ADDR_WIDTH = 24;

   // Slave select field of the adapter window
   localparam int SLAVE_LSB = 20;
   localparam int SLAVE_W   = 4;
   localparam logic [SLAVE_W-1:0] SLAVE_CONF = 4'h0;
   localparam logic [SLAVE_W-1:0] SLAVE_MP   = 4'h1;

   // Offsets inside a slave
   localparam logic [SLAVE_LSB-1:0] REG_DATA        = 20'h0;
   localparam logic [SLAVE_LSB-1:0] REG_STATUS      = 20'h4;
   localparam logic [SLAVE_LSB-1:0] CONF_TILE_ID    = 20'h0;
   localparam logic [SLAVE_LSB-1:0] CONF_FEATURES   = 20'h4;
   localparam logic [SLAVE_LSB-1:0] CONF_FLIT_WIDTH = 20'h8;

   localparam logic [15:0] TILE_ID = 16'h0005;
   localparam int FEATURE_MP = 0;  // Bit index, DMA bit 1 stays clear

   // Class field of the header flit
   localparam int CLASS_LSB = 24;
   localparam int CLASS_W   = 3;
   localparam logic [CLASS_W-1:0] CLASS_MP = 3'd0;

   // Buffer sizes
   localparam int IN_DEPTH  = 4;
   localparam int OUT_DEPTH = 4;
   localparam int RX_DEPTH  = 16;
   localparam int RX_PKTS   = 4;
   localparam int MAX_PKT   = 16;

   typedef logic [31:0]             word_t;
   typedef logic [ADDR_WIDTH-1:0]   addr_t;
   typedef logic [FLIT_WIDTH-1:0]   flit_t;
   typedef logic [$clog2(MAX_PKT+1)-1:0] size_t;  // 1 .. MAX_PKT flits

   typedef struct packed {
      logic  last;
      flit_t flit;
   } noc_flit_t;

endpackage

// File: noc_fifo.sv
/*
 * Valid/ready FIFO, circular buffer with a generic payload type
 */
`timescale 1ns/1ns

module noc_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     reset_i,
   input  payload_t in_data_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output payload_t out_data_o,
   output logic     out_valid_o,
   input  logic     out_ready_i
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push, pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      return ptr + PTR_W'(1);
   endfunction

   assign in_ready_o  = (count_q != CNT_W'(DEPTH));
   assign out_valid_o = (count_q != '0);
   assign out_data_o  = mem[rd_ptr_q];  // Head of queue
   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr_q] <= in_data_i;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
         if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
         case ({push, pop})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;  // Both or none
         endcase
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (reset_i)
      count_q <= CNT_W'(DEPTH));

   // Equal pointers while not full mean an empty buffer
   a_empty_idle: assert property (@(posedge clk) disable iff (reset_i)
      (wr_ptr_q == rd_ptr_q && in_ready_o) |-> !out_valid_o);

endmodule

// File: na_class_filter.sv
/*
 * Ingress class filter, forwards message-passing packets and drops the rest
 */
`timescale 1ns/1ns

module na_class_filter import na_pkg::*; (
   input  logic      clk,
   input  logic      reset_i,
   input  noc_flit_t in_data_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   output noc_flit_t out_data_o,
   output logic      out_valid_o,
   input  logic      out_ready_i
);
   logic hdr_q;   // Next flit starts a packet
   logic mp_q;    // Class decision of the current packet
   logic hdr_mp, pass, xfer;

   assign hdr_mp = (in_data_i.flit[CLASS_LSB +: CLASS_W] == CLASS_MP);
   assign pass   = hdr_q ? hdr_mp : mp_q;

   assign out_data_o  = in_data_i;
   assign out_valid_o = in_valid_i && pass;
   assign in_ready_o  = pass ? out_ready_i : 1'b1;  // Dropped flits always sink
   assign xfer        = in_valid_i && in_ready_o;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         hdr_q <= 1'b1;
         mp_q  <= 1'b0;
      end else if (xfer) begin
         hdr_q <= in_data_i.last;
         if (hdr_q)
            mp_q <= hdr_mp;  // Held until last
      end
   end

endmodule

// File: mp_send.sv
/*
 * Message send path, turns a size word and its data words into NoC flits
 */
`timescale 1ns/1ns

module mp_send import na_pkg::*; (
   input  logic      clk,
   input  logic      reset_i,
   input  logic      mp_wr_i,
   input  word_t     mp_wdata_i,
   output logic      wr_ready_o,
   output noc_flit_t out_data_o,
   output logic      out_valid_o,
   input  logic      out_ready_i
);
   logic      wr_q;
   word_t     wdata_q;
   size_t     remain_q;  // Flits still owed, 0 while a size word is expected
   noc_flit_t push_data;
   logic      push_valid, push_ready;

   assign push_valid      = wr_q && (remain_q != '0);
   assign push_data.flit  = wdata_q;
   assign push_data.last  = (remain_q == size_t'(1));
   assign wr_ready_o      = push_ready;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_q     <= 1'b0;
         remain_q <= '0;
      end else begin
         wr_q <= mp_wr_i;
         if (wr_q)
            remain_q <= (remain_q == '0) ? size_t'(wdata_q) : remain_q - size_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (mp_wr_i)
         wdata_q <= mp_wdata_i;
   end

   noc_fifo #(.payload_t(noc_flit_t), .DEPTH(OUT_DEPTH)) u_egress (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_data_i   (push_data),
      .in_valid_i  (push_valid),
      .in_ready_o  (push_ready),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   a_size_range: assert property (@(posedge clk) disable iff (reset_i)
      (wr_q && remain_q == '0) |-> (wdata_q != '0 && wdata_q <= word_t'(MAX_PKT)));

   // Decoder only accepts a write when the FIFO has room
   a_no_drop: assert property (@(posedge clk) disable iff (reset_i)
      push_valid |-> push_ready);

endmodule

// File: mp_recv.sv
/*
 * Message receive buffer, stores arriving flits with a queue of packet sizes
 * and hands them to software size first
 */
`timescale 1ns/1ns

module mp_recv import na_pkg::*; (
   input  logic      clk,
   input  logic      reset_i,
   input  noc_flit_t in_data_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   input  logic      mp_rd_i,
   output word_t     rd_data_o,
   output logic      pkt_avail_o
);
   noc_flit_t flit_head;
   size_t     size_head;
   size_t     cnt_q;       // Flits of the arriving packet so far
   logic      sent_size_q; // Size of head packet already read
   logic      flit_in_ready, size_in_ready, flit_out_valid;
   logic      accept, flit_pop, size_pop;

   assign in_ready_o = flit_in_ready && size_in_ready;
   assign accept     = in_valid_i && in_ready_o;

   assign flit_pop = mp_rd_i && pkt_avail_o && sent_size_q && flit_out_valid;
   assign size_pop = flit_pop && flit_head.last;  // Packet fully read

   always_comb begin
      if (!pkt_avail_o)
         rd_data_o = '0;
      else if (!sent_size_q)
         rd_data_o = word_t'(size_head);
      else
         rd_data_o = flit_head.flit;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         cnt_q       <= '0;
         sent_size_q <= 1'b0;
      end else begin
         if (accept)
            cnt_q <= in_data_i.last ? '0 : cnt_q + size_t'(1);
         if (mp_rd_i && pkt_avail_o && !sent_size_q)
            sent_size_q <= 1'b1;
         else if (size_pop)
            sent_size_q <= 1'b0;
      end
   end

   noc_fifo #(.payload_t(noc_flit_t), .DEPTH(RX_DEPTH)) u_flits (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_data_i   (in_data_i),
      .in_valid_i  (accept),
      .in_ready_o  (flit_in_ready),
      .out_data_o  (flit_head),
      .out_valid_o (flit_out_valid),
      .out_ready_i (flit_pop)
   );

   noc_fifo #(.payload_t(size_t), .DEPTH(RX_PKTS)) u_sizes (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_data_i   (cnt_q + size_t'(1)),  // Count including the last flit
      .in_valid_i  (accept && in_data_i.last),
      .in_ready_o  (size_in_ready),
      .out_data_o  (size_head),
      .out_valid_o (pkt_avail_o),
      .out_ready_i (size_pop)
   );

endmodule

// File: na_bus_decode.sv
/*
 * Bus slave of the adapter window, decodes configuration and message buffer
 * accesses and returns the registered response
 */
`timescale 1ns/1ns

module na_bus_decode import na_pkg::*; (
   input  logic  clk,
   input  logic  reset_i,
   input  logic  bus_stb_i,
   input  logic  bus_we_i,
   input  addr_t bus_adr_i,
   input  word_t bus_dat_i,
   output word_t bus_dat_o,
   output logic  bus_ack_o,
   output logic  bus_err_o,
   output logic  mp_wr_o,
   output word_t mp_wdata_o,
   input  logic  wr_ready_i,
   output logic  mp_rd_o,
   input  word_t rd_data_i,
   input  logic  pkt_avail_i
);
   logic [SLAVE_W-1:0]   slave;
   logic [SLAVE_LSB-1:0] offs;
   logic                 is_data, accept, err;
   word_t                rdata;

   assign slave   = bus_adr_i[SLAVE_LSB +: SLAVE_W];
   assign offs    = bus_adr_i[SLAVE_LSB-1:0];
   assign is_data = (slave == SLAVE_MP) && (offs == REG_DATA);

   // Data writes wait for room in the send path
   assign accept = bus_stb_i && !bus_ack_o && !(is_data && bus_we_i && !wr_ready_i);

   assign mp_wr_o    = accept && is_data && bus_we_i;
   assign mp_rd_o    = accept && is_data && !bus_we_i;
   assign mp_wdata_o = bus_dat_i;

   always_comb begin
      rdata = '0;
      err   = 1'b0;
      case (slave)
         SLAVE_CONF: begin
            case (offs)
               CONF_TILE_ID:    rdata = word_t'(TILE_ID);
               CONF_FEATURES:   rdata[FEATURE_MP] = 1'b1;
               CONF_FLIT_WIDTH: rdata = word_t'(FLIT_WIDTH);
               default:         err = 1'b1;
            endcase
         end
         SLAVE_MP: begin
            case (offs)
               REG_DATA:   rdata = rd_data_i;  // Size or flit at buffer head
               REG_STATUS: rdata[0] = pkt_avail_i;
               default:    err = 1'b1;
            endcase
         end
         default: err = 1'b1;  // No slave behind this select
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         bus_ack_o <= 1'b0;
         bus_err_o <= 1'b0;
      end else begin
         bus_ack_o <= accept;
         bus_err_o <= accept && err;
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         bus_dat_o <= (bus_we_i || err) ? '0 : rdata;
   end

   a_ack_pulse: assert property (@(posedge clk) disable iff (reset_i)
      bus_ack_o |=> !bus_ack_o);

endmodule

// File: na_top.sv
/*
 * Network adapter top, bus slave plus message send and receive over one
 * NoC channel pair
 */
`timescale 1ns/1ns

module na_top import na_pkg::*; (
   input  logic  clk,
   input  logic  reset_i,
   input  logic  bus_stb_i,
   input  logic  bus_we_i,
   input  addr_t bus_adr_i,
   input  word_t bus_dat_i,
   output word_t bus_dat_o,
   output logic  bus_ack_o,
   output logic  bus_err_o,
   input  flit_t noc_in_flit_i,
   input  logic  noc_in_last_i,
   input  logic  noc_in_valid_i,
   output logic  noc_in_ready_o,
   output flit_t noc_out_flit_o,
   output logic  noc_out_last_o,
   output logic  noc_out_valid_o,
   input  logic  noc_out_ready_i,
   output logic  irq_o
);
   noc_flit_t noc_in_data, in_q_data, filt_data, tx_data;
   logic      in_q_valid, in_q_ready, filt_valid, filt_ready;
   logic      mp_wr, wr_ready, mp_rd, pkt_avail;
   word_t     mp_wdata, rd_data;

   assign noc_in_data.flit = noc_in_flit_i;
   assign noc_in_data.last = noc_in_last_i;
   assign noc_out_flit_o   = tx_data.flit;
   assign noc_out_last_o   = tx_data.last;
   assign irq_o            = pkt_avail;

   noc_fifo #(.payload_t(noc_flit_t), .DEPTH(IN_DEPTH)) u_ingress (
      .clk(clk), .reset_i(reset_i),
      .in_data_i(noc_in_data), .in_valid_i(noc_in_valid_i), .in_ready_o(noc_in_ready_o),
      .out_data_o(in_q_data), .out_valid_o(in_q_valid), .out_ready_i(in_q_ready)
   );

   na_class_filter u_filter (
      .clk(clk), .reset_i(reset_i),
      .in_data_i(in_q_data), .in_valid_i(in_q_valid), .in_ready_o(in_q_ready),
      .out_data_o(filt_data), .out_valid_o(filt_valid), .out_ready_i(filt_ready)
   );

   mp_recv u_recv (
      .clk(clk), .reset_i(reset_i),
      .in_data_i(filt_data), .in_valid_i(filt_valid), .in_ready_o(filt_ready),
      .mp_rd_i(mp_rd), .rd_data_o(rd_data), .pkt_avail_o(pkt_avail)
   );

   mp_send u_send (
      .clk(clk), .reset_i(reset_i),
      .mp_wr_i(mp_wr), .mp_wdata_i(mp_wdata), .wr_ready_o(wr_ready),
      .out_data_o(tx_data), .out_valid_o(noc_out_valid_o), .out_ready_i(noc_out_ready_i)
   );

   na_bus_decode u_decode (
      .clk(clk), .reset_i(reset_i),
      .bus_stb_i(bus_stb_i), .bus_we_i(bus_we_i), .bus_adr_i(bus_adr_i),
      .bus_dat_i(bus_dat_i), .bus_dat_o(bus_dat_o),
      .bus_ack_o(bus_ack_o), .bus_err_o(bus_err_o),
      .mp_wr_o(mp_wr), .mp_wdata_o(mp_wdata), .wr_ready_i(wr_ready),
      .mp_rd_o(mp_rd), .rd_data_i(rd_data), .pkt_avail_i(pkt_avail)
   );

endmodule

// File: tb_na_top.sv
/*
 * Testbench of the network adapter, random send and receive traffic checked
 * against queue-based reference models
 */
`timescale 1ns/1ns

module tb_na_top import na_pkg::*; ();

   localparam int NUM_TX = 24;
   localparam int NUM_RX = 32;
   localparam int WATCHDOG_CYCLES = (NUM_TX + NUM_RX) * 200 + 1000;

   logic  clk, reset_i;
   logic  bus_stb_i, bus_we_i, bus_ack_o, bus_err_o;
   addr_t bus_adr_i;
   word_t bus_dat_i, bus_dat_o;
   flit_t noc_in_flit_i, noc_out_flit_o;
   logic  noc_in_last_i, noc_in_valid_i, noc_in_ready_o;
   logic  noc_out_last_o, noc_out_valid_o, noc_out_ready_i, irq_o;

   noc_flit_t exp_tx[$];    // Flits expected on the NoC output
   flit_t     rx_flits[$];  // Ingress stimulus
   logic      rx_lasts[$];
   word_t     exp_rd[$];    // Sizes and flits of message-passing packets
   int        num_mp;

   na_top na_top_i (.*);

   always #50 clk = ~clk;

   always @(posedge clk)
      noc_out_ready_i <= ($urandom_range(0, 3) == 0);  // Slow sink fills the egress FIFO

   task automatic abort_run(input string what);
      $display("Test FAILED");
      $fatal(1, "%s", what);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         abort_run("Bus data differs from the model");
      end
   endtask

   task automatic check_flit(input string name, input noc_flit_t got, input noc_flit_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         abort_run("NoC output flit differs from the model");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         abort_run("Control signal has the wrong level");
      end
   endtask

   // Egress monitor, every transfer must match the head of the model
   always @(posedge clk) begin
      if (!reset_i && noc_out_valid_o && noc_out_ready_i) begin
         if (exp_tx.size() == 0)
            abort_run("Flit left the NoC output with none expected");
         else
            check_flit("{noc_out_last_o, noc_out_flit_o}",
                       {noc_out_last_o, noc_out_flit_o}, exp_tx.pop_front());
      end
   end

   function automatic addr_t make_addr(input logic [SLAVE_W-1:0] slave,
                                       input logic [SLAVE_LSB-1:0] offs);
      return {slave, offs};
   endfunction

   // One bus access, strobe held until ack
   task automatic bus_access(input logic we, input addr_t adr, input word_t wdata,
                             output word_t rdata, output logic err);
      @(posedge clk);
      bus_stb_i <= 1'b1;
      bus_we_i  <= we;
      bus_adr_i <= adr;
      bus_dat_i <= wdata;
      do @(posedge clk); while (!bus_ack_o);
      rdata = bus_dat_o;
      err   = bus_err_o;
      bus_stb_i <= 1'b0;
   endtask

   task automatic read_expect(input addr_t adr, input word_t exp_data, input logic exp_err);
      word_t rdata;
      logic  err;
      bus_access(1'b0, adr, '0, rdata, err);
      check_bit("bus_err_o", err, exp_err);
      check_word("bus_dat_o", rdata, exp_data);
   endtask

   task automatic write_expect(input addr_t adr, input word_t wdata, input logic exp_err);
      word_t rdata;
      logic  err;
      bus_access(1'b1, adr, wdata, rdata, err);
      check_bit("bus_err_o", err, exp_err);
      if (exp_err)
         check_word("bus_dat_o", rdata, '0);
   endtask

   task automatic send_packet();
      int        n;
      noc_flit_t nf;
      n = $urandom_range(1, MAX_PKT);
      write_expect(make_addr(SLAVE_MP, REG_DATA), word_t'(n), 1'b0);  // Size word first
      for (int i = 0; i < n; i++) begin
         nf.flit = $urandom;
         nf.last = (i == n - 1);
         exp_tx.push_back(nf);
         write_expect(make_addr(SLAVE_MP, REG_DATA), nf.flit, 1'b0);
      end
   endtask

   task automatic build_rx_packets();
      int    n;
      logic  mp;
      flit_t f;
      num_mp = 0;
      for (int p = 0; p < NUM_RX; p++) begin
         mp = ($urandom_range(0, 2) != 0);
         n  = $urandom_range(1, MAX_PKT);
         if (mp) begin
            num_mp++;
            exp_rd.push_back(word_t'(n));
         end
         for (int i = 0; i < n; i++) begin
            f = $urandom;
            if (i == 0)
               f[CLASS_LSB +: CLASS_W] = mp ? CLASS_MP : CLASS_W'($urandom_range(1, 7));
            rx_flits.push_back(f);
            rx_lasts.push_back(i == n - 1);
            if (mp)
               exp_rd.push_back(f);
         end
      end
   endtask

   task automatic drive_rx();
      @(posedge clk);
      while (rx_flits.size() != 0) begin
         noc_in_flit_i  <= rx_flits.pop_front();
         noc_in_last_i  <= rx_lasts.pop_front();
         noc_in_valid_i <= 1'b1;
         do @(posedge clk); while (!noc_in_ready_o);
         if ($urandom_range(0, 3) == 0) begin  // Idle gap now and then
            noc_in_valid_i <= 1'b0;
            @(posedge clk);
         end
      end
      noc_in_valid_i <= 1'b0;
   endtask

   task automatic read_rx();
      word_t sz;
      for (int p = 0; p < num_mp; p++) begin
         while (!irq_o) @(posedge clk);
         read_expect(make_addr(SLAVE_MP, REG_STATUS), 32'h1, 1'b0);
         sz = exp_rd.pop_front();
         read_expect(make_addr(SLAVE_MP, REG_DATA), sz, 1'b0);
         for (int i = 0; i < int'(sz); i++)
            read_expect(make_addr(SLAVE_MP, REG_DATA), exp_rd.pop_front(), 1'b0);
      end
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run("Watchdog expired before the tests finished");
   end

   initial begin
      void'($urandom(32'h1678));
      clk             = 1'b0;
      reset_i         = 1'b1;
      bus_stb_i       = 1'b0;
      bus_we_i        = 1'b0;
      bus_adr_i       = '0;
      bus_dat_i       = '0;
      noc_in_flit_i   = '0;
      noc_in_last_i   = 1'b0;
      noc_in_valid_i  = 1'b0;
      noc_out_ready_i = 1'b0;
      repeat (10) @(posedge clk);
      reset_i <= 1'b0;
      @(posedge clk);
      check_bit("bus_ack_o", bus_ack_o, 1'b0);
      check_bit("bus_err_o", bus_err_o, 1'b0);
      check_bit("noc_out_valid_o", noc_out_valid_o, 1'b0);
      check_bit("irq_o", irq_o, 1'b0);
      check_bit("noc_in_ready_o", noc_in_ready_o, 1'b1);

      // Configuration block, writes are ignored
      read_expect(make_addr(SLAVE_CONF, CONF_TILE_ID), 32'h5, 1'b0);
      read_expect(make_addr(SLAVE_CONF, CONF_FEATURES), 32'h1, 1'b0);
      read_expect(make_addr(SLAVE_CONF, CONF_FLIT_WIDTH), 32'd32, 1'b0);
      write_expect(make_addr(SLAVE_CONF, CONF_TILE_ID), $urandom, 1'b0);
      read_expect(make_addr(SLAVE_CONF, CONF_TILE_ID), 32'h5, 1'b0);

      for (int i = 0; i < 8; i++) begin
         read_expect(make_addr(SLAVE_W'($urandom_range(2, 15)),
                               SLAVE_LSB'({$urandom_range(0, 255), 2'b00})), '0, 1'b1);
         write_expect(make_addr(SLAVE_W'($urandom_range(2, 15)), '0), $urandom, 1'b1);
      end
      read_expect(make_addr(SLAVE_CONF, 20'hC), '0, 1'b1);
      read_expect(make_addr(SLAVE_MP, 20'h8), '0, 1'b1);
      write_expect(make_addr(SLAVE_MP, 20'h10), $urandom, 1'b1);

      // Nothing received yet
      read_expect(make_addr(SLAVE_MP, REG_DATA), '0, 1'b0);
      read_expect(make_addr(SLAVE_MP, REG_STATUS), '0, 1'b0);

      repeat (NUM_TX) send_packet();
      while (exp_tx.size() != 0) @(posedge clk);

      build_rx_packets();
      fork
         drive_rx();
         read_rx();
      join
      check_bit("irq_o", irq_o, 1'b0);
      read_expect(make_addr(SLAVE_MP, REG_STATUS), '0, 1'b0);
      read_expect(make_addr(SLAVE_MP, REG_DATA), '0, 1'b0);

      $display("Test OK");
      $finish;
   end

endmodule

// File: sources.f
na_pkg.sv
noc_fifo.sv
na_class_filter.sv
mp_send.sv
mp_recv.sv
na_bus_decode.sv
na_top.sv
tb_na_top.sv

// File: run.sh
#!/bin/sh
# Build the network adapter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_na_top -o tb_na_top
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/tb_na_top
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi
exit 0
